//--- rtl/drm_pkg.sv
////////////////////////////////////////////////////////////
// Shared sizes and bus structs of the LLR input buffer write side
// Top level N_USERS must not exceed MAX_USERS
////////////////////////////////////////////////////////////

package drm_pkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////
	localparam int MAX_USERS = 8;
	localparam int N_BANKS   = 16;
	localparam int LLR_W     = 6;
	localparam int BANK_W    = 48;
	localparam int RE_ADDR_W = 14;
	localparam int ROW_W     = 10;   // Address bits 13..4
	localparam int SZ_W      = 16;   // E0/E1 size fields
	localparam int CB_W      = 8;    // Code-block counts
	localparam int QM_W      = 4;
	localparam int UIDX_W    = 4;
	localparam int RX_LLRS   = 16;   // LLRs per demux beat

	////////////////////////////////////////////////////////////
	// Structs
	////////////////////////////////////////////////////////////

	// One user's slot settings, stable for the whole slot
	typedef struct packed {
		logic [SZ_W-1:0] e0_sz;      // Last RE index of an E0 code block
		logic [SZ_W-1:0] e1_sz;      // Last RE index of an E1 code block
		logic [CB_W-1:0] e0_num;     // Code blocks using E0
		logic [QM_W-1:0] qm;
		logic            two_layer;
	} user_cfg_t;

	typedef struct packed {
		logic [RE_ADDR_W-1:0] re_addr;
		logic                 page;
	} user_state_t;

	typedef struct packed {
		logic [UIDX_W-1:0]          user_idx;
		logic [RX_LLRS*LLR_W-1:0]   rx;
	} demux_beat_t;

	// Row is page bit on top of the ROW_W row bits
	typedef struct packed {
		logic [ROW_W:0]                    row;
		logic [N_BANKS-1:0]                en;
		logic [N_BANKS-1:0][BANK_W-1:0]    data;
	} buf_wr_t;

endpackage

//--- rtl/drm_start_calc.sv
////////////////////////////////////////////////////////////
// Walks the users once per slot, one user per cycle
// Load pulse comes N_USERS edges after slot start
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module drm_start_calc #(
	parameter int N_USERS = 8
) (
	input  logic                                       i_core_clk,
	input  logic                                       i_rx_rstn,
	input  logic                                       i_slot_start,
	input  drm_pkg::user_cfg_t [N_USERS-1:0]           i_user_cfg,
	output logic [N_USERS-1:0][drm_pkg::RE_ADDR_W-1:0] o_start,
	output logic                                       o_start_load
);

	localparam int CNT_W = $clog2(drm_pkg::MAX_USERS + 1);
	localparam int AW    = drm_pkg::RE_ADDR_W;

	logic [CNT_W-1:0]   step_cnt;
	logic               busy;
	logic [AW-1:0]      sum;
	logic [AW-5:0]      blk_num;
	drm_pkg::user_cfg_t cur_cfg;

	assign cur_cfg = i_user_cfg[step_cnt];
	assign blk_num = cur_cfg.e1_sz[AW-1:4] + 1'b1;  // E1 rounded up to 16-RE blocks

	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
		begin
			step_cnt     <= '0;
			busy         <= 1'b0;
			sum          <= '0;
			o_start_load <= 1'b0;
		end
		else
		begin
			o_start_load <= 1'b0;
			if (i_slot_start)
			begin
				step_cnt <= '0;
				busy     <= 1'b1;
				sum      <= '0;
			end
			else if (busy)
			begin
				sum      <= sum + {blk_num, 4'b0000};
				step_cnt <= step_cnt + 1'b1;
				if (step_cnt == (CNT_W)'(N_USERS - 1))
				begin
					busy         <= 1'b0;   // Counter holds at N_USERS
					o_start_load <= 1'b1;
				end
			end
		end
	end

	// Start is the sum before this user's own size
	always_ff @(posedge i_core_clk)
	begin
		if (busy && !i_slot_start)
			o_start[step_cnt] <= sum;
	end

endmodule

//--- rtl/drm_user_tracker.sv
////////////////////////////////////////////////////////////
// Per-user RE address tracking across code blocks
// A hit must not coincide with slot start or start load
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module drm_user_tracker (
	input  logic                          i_core_clk,
	input  logic                          i_rx_rstn,
	input  logic                          i_slot_start,
	input  logic                          i_start_load,
	input  logic [drm_pkg::RE_ADDR_W-1:0] i_start,
	input  drm_pkg::user_cfg_t            i_cfg,
	input  logic                          i_hit,
	output drm_pkg::user_state_t          o_state
);

	localparam int AW = drm_pkg::RE_ADDR_W;

	logic [AW-1:0]            re_cnt;
	logic [AW-1:0]            re_addr;
	logic                     page;
	logic [drm_pkg::CB_W-1:0] cb_cnt;
	logic [drm_pkg::SZ_W-1:0] limit;
	logic [AW-1:0]            step;
	logic                     in_cb;

	// E0 length until e0_num blocks are done
	assign limit = (cb_cnt < i_cfg.e0_num) ? i_cfg.e0_sz : i_cfg.e1_sz;
	assign step  = i_cfg.two_layer ? (AW)'(2) : (AW)'(1);
	assign in_cb = {{(drm_pkg::SZ_W - AW){1'b0}}, re_cnt} < limit;

	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
		begin
			re_cnt  <= '0;
			re_addr <= '0;
			page    <= 1'b0;
			cb_cnt  <= '0;
		end
		else if (i_slot_start)
		begin
			re_cnt <= '0;
			page   <= 1'b0;
			cb_cnt <= '0;
		end
		else if (i_start_load)
			re_addr <= i_start;
		else if (i_hit)
		begin
			if (in_cb)
			begin
				re_cnt  <= re_cnt + step;
				re_addr <= re_addr + step;
			end
			else
			begin
				// Code block done, next one goes to the other page
				re_cnt  <= '0;
				re_addr <= i_start;
				page    <= ~page;
				cb_cnt  <= cb_cnt + 1'b1;
			end
		end
	end

	assign o_state.re_addr = re_addr;
	assign o_state.page    = page;

endmodule

//--- rtl/drm_wr_format.sv
////////////////////////////////////////////////////////////
// Turns one demux beat into one buffer write, fully combinational
// Qm other than 1, 2, 4, 6 or 8 writes zeros on two-layer beats
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module drm_wr_format #(
	parameter int N_USERS = 8
) (
	input  logic                                i_beat_strb,
	input  drm_pkg::demux_beat_t                i_beat,
	input  drm_pkg::user_cfg_t   [N_USERS-1:0]  i_user_cfg,
	input  drm_pkg::user_state_t [N_USERS-1:0]  i_state,
	output logic [N_USERS-1:0]                  o_user_hit,
	output drm_pkg::buf_wr_t                    o_wr
);

	localparam int LW = drm_pkg::LLR_W;
	localparam int BW = drm_pkg::BANK_W;
	localparam int AW = drm_pkg::RE_ADDR_W;

	logic                         user_ok;
	drm_pkg::user_state_t         sel_state;
	logic [drm_pkg::QM_W-1:0]     sel_qm;
	logic                         sel_two;
	logic [BW-1:0]                even_word;
	logic [BW-1:0]                odd_word;
	logic [3:0]                   bank_lo;
	logic [drm_pkg::N_BANKS-1:0]  bank_sel;

	assign user_ok = i_beat.user_idx < (drm_pkg::UIDX_W)'(N_USERS);

	////////////////////////////////////////////////////////////
	// User decode and select
	////////////////////////////////////////////////////////////
	always_comb
	begin
		sel_state = '0;
		sel_qm    = '0;
		sel_two   = 1'b0;
		for (int u = 0; u < N_USERS; u++)
		begin
			o_user_hit[u] = 1'b0;
			if (user_ok && i_beat.user_idx == (drm_pkg::UIDX_W)'(u))
			begin
				o_user_hit[u] = i_beat_strb;
				sel_state     = i_state[u];
				sel_qm        = i_user_cfg[u].qm;
				sel_two       = i_user_cfg[u].two_layer;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Two-layer packing, one Qm group per bank of the pair
	////////////////////////////////////////////////////////////
	always_comb
	begin
		even_word = '0;
		odd_word  = '0;
		case (sel_qm)
			4'd1:
			begin
				even_word = (BW)'(i_beat.rx[LW-1:0]);
				odd_word  = (BW)'(i_beat.rx[2*LW-1:LW]);
			end
			4'd2:
			begin
				even_word = (BW)'(i_beat.rx[2*LW-1:0]);
				odd_word  = (BW)'(i_beat.rx[4*LW-1:2*LW]);
			end
			4'd4:
			begin
				even_word = (BW)'(i_beat.rx[4*LW-1:0]);
				odd_word  = (BW)'(i_beat.rx[8*LW-1:4*LW]);
			end
			4'd6:
			begin
				even_word = (BW)'(i_beat.rx[6*LW-1:0]);
				odd_word  = (BW)'(i_beat.rx[12*LW-1:6*LW]);
			end
			4'd8:
			begin
				even_word = i_beat.rx[8*LW-1:0];
				odd_word  = i_beat.rx[16*LW-1:8*LW];
			end
			default:
			begin
				even_word = '0;
				odd_word  = '0;
			end
		endcase
	end

	assign bank_lo  = sel_state.re_addr[3:0];
	assign bank_sel = sel_two ? (16'h0003 << {bank_lo[3:1], 1'b0})  // Bank pair 2p, 2p+1
	                          : (16'h0001 << bank_lo);

	always_comb
	begin
		o_wr.row = {sel_state.page, sel_state.re_addr[AW-1:4]};
		o_wr.en  = (|o_user_hit) ? bank_sel : '0;
		for (int b = 0; b < drm_pkg::N_BANKS; b++)
		begin
			if (!sel_two)
				o_wr.data[b] = i_beat.rx[BW-1:0];
			else if (b % 2 == 0)
				o_wr.data[b] = even_word;
			else
				o_wr.data[b] = odd_word;
		end
	end

endmodule

//--- rtl/drm_llr_buffer.sv
////////////////////////////////////////////////////////////
// 16-bank LLR buffer, read address is {page, row, bank}
// Read data follows two edges after the request is sampled
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module drm_llr_buffer #(
	parameter int DEPTH_W = 11
) (
	input  logic                         i_core_clk,
	input  logic                         i_rx_rstn,
	input  drm_pkg::buf_wr_t             i_wr,
	input  logic                         i_rd_req,
	input  logic [DEPTH_W+3:0]           i_rd_addr,
	output logic                         o_rd_ack,
	output logic [drm_pkg::BANK_W-1:0]   o_rd_data
);

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_FETCH,
		RD_OUT,
		RD_ACK
	} rd_state_t;

	logic [drm_pkg::BANK_W-1:0] mem [drm_pkg::N_BANKS][2**DEPTH_W];
	logic [DEPTH_W-1:0]         wr_row;
	logic [DEPTH_W-1:0]         rd_row;
	logic [3:0]                 rd_bank;
	logic [drm_pkg::BANK_W-1:0] rd_word;
	rd_state_t                  rd_state;

	assign wr_row = i_wr.row[DEPTH_W-1:0];

	always_ff @(posedge i_core_clk)
	begin
		for (int b = 0; b < drm_pkg::N_BANKS; b++)
		begin
			if (i_wr.en[b])
				mem[b][wr_row] <= i_wr.data[b];
		end
	end

	////////////////////////////////////////////////////////////
	// Four-phase read port
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_core_clk or negedge i_rx_rstn)
	begin
		if (!i_rx_rstn)
			rd_state <= RD_IDLE;
		else
		begin
			case (rd_state)
				RD_IDLE:  if (i_rd_req) rd_state <= RD_FETCH;
				RD_FETCH: rd_state <= RD_OUT;
				RD_OUT:   rd_state <= RD_ACK;
				RD_ACK:   if (!i_rd_req) rd_state <= RD_IDLE;  // Ack drops one edge after req
				default:  rd_state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_core_clk)
	begin
		if (rd_state == RD_IDLE && i_rd_req)
		begin
			rd_row  <= i_rd_addr[DEPTH_W+3:4];
			rd_bank <= i_rd_addr[3:0];
		end
		if (rd_state == RD_FETCH)
			rd_word <= mem[rd_bank][rd_row];
		if (rd_state == RD_OUT)
			o_rd_data <= rd_word;
	end

	assign o_rd_ack = (rd_state == RD_ACK);

endmodule

//--- rtl/drm_top.sv
////////////////////////////////////////////////////////////
// LLR input buffer write side with a read-back port
// Beats start no earlier than N_USERS + 2 cycles after slot start
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module drm_top #(
	parameter int N_USERS = 8,
	parameter int DEPTH_W = 11
) (
	input  logic                               i_core_clk,
	input  logic                               i_rx_rstn,
	input  logic                               i_slot_start,
	input  drm_pkg::user_cfg_t [N_USERS-1:0]   i_user_cfg,
	input  logic                               i_beat_strb,
	input  drm_pkg::demux_beat_t               i_beat,
	input  logic                               i_rd_req,
	input  logic [DEPTH_W+3:0]                 i_rd_addr,
	output logic                               o_rd_ack,
	output logic [drm_pkg::BANK_W-1:0]         o_rd_data
);

	logic [N_USERS-1:0][drm_pkg::RE_ADDR_W-1:0] start;
	logic                                       start_load;
	logic [N_USERS-1:0]                         user_hit;
	drm_pkg::user_state_t [N_USERS-1:0]         state;
	drm_pkg::buf_wr_t                           wr;

	////////////////////////////////////////////////////////////
	// Start addresses and per-user trackers
	////////////////////////////////////////////////////////////
	drm_start_calc #(
		.N_USERS      (N_USERS)
	) u_start_calc (
		.i_core_clk   (i_core_clk),
		.i_rx_rstn    (i_rx_rstn),
		.i_slot_start (i_slot_start),
		.i_user_cfg   (i_user_cfg),
		.o_start      (start),
		.o_start_load (start_load)
	);

	for (genvar u = 0; u < N_USERS; u++)
	begin : g_user
		drm_user_tracker u_tracker (
			.i_core_clk   (i_core_clk),
			.i_rx_rstn    (i_rx_rstn),
			.i_slot_start (i_slot_start),
			.i_start_load (start_load),
			.i_start      (start[u]),
			.i_cfg        (i_user_cfg[u]),
			.i_hit        (user_hit[u]),
			.o_state      (state[u])
		);
	end

	////////////////////////////////////////////////////////////
	// Write formatting and storage
	////////////////////////////////////////////////////////////
	drm_wr_format #(
		.N_USERS     (N_USERS)
	) u_wr_format (
		.i_beat_strb (i_beat_strb),
		.i_beat      (i_beat),
		.i_user_cfg  (i_user_cfg),
		.i_state     (state),
		.o_user_hit  (user_hit),
		.o_wr        (wr)
	);

	drm_llr_buffer #(
		.DEPTH_W    (DEPTH_W)
	) u_llr_buffer (
		.i_core_clk (i_core_clk),
		.i_rx_rstn  (i_rx_rstn),
		.i_wr       (wr),
		.i_rd_req   (i_rd_req),
		.i_rd_addr  (i_rd_addr),
		.o_rd_ack   (o_rd_ack),
		.o_rd_data  (o_rd_data)
	);

endmodule

//--- verif/tb_drm_top.sv
////////////////////////////////////////////////////////////
// Directed tests of the LLR buffer write side through the read port
// Built with N_USERS = 8 and the default DEPTH_W of 11
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_drm_top;

	localparam int NU  = 8;
	localparam int TMO = 20;   // Cycles allowed per handshake wait

	logic                        i_core_clk;
	logic                        i_rx_rstn;
	logic                        i_slot_start;
	drm_pkg::user_cfg_t [NU-1:0] i_user_cfg;
	logic                        i_beat_strb;
	drm_pkg::demux_beat_t        i_beat;
	logic                        i_rd_req;
	logic [14:0]                 i_rd_addr;
	logic                        o_rd_ack;
	logic [47:0]                 o_rd_data;

	// Reference model of the trackers and the buffer contents
	logic [13:0] m_start [NU];
	logic [13:0] m_cnt   [NU];
	logic [13:0] m_addr  [NU];
	logic        m_page  [NU];
	int          m_cb    [NU];
	logic [47:0] exp_mem [32768];
	bit          exp_vld [32768];
	logic [95:0] rx_hist [32];
	integer      seed   = 35092;
	int          errors = 0;
	int          checks = 0;

	drm_top #(
		.N_USERS      (NU),
		.DEPTH_W      (11)
	) i_drm_top (
		.i_core_clk   (i_core_clk),
		.i_rx_rstn    (i_rx_rstn),
		.i_slot_start (i_slot_start),
		.i_user_cfg   (i_user_cfg),
		.i_beat_strb  (i_beat_strb),
		.i_beat       (i_beat),
		.i_rd_req     (i_rd_req),
		.i_rd_addr    (i_rd_addr),
		.o_rd_ack     (o_rd_ack),
		.o_rd_data    (o_rd_data)
	);

	always #20 i_core_clk = ~i_core_clk;

	task automatic tick();
		@(posedge i_core_clk);
		#2;
	endtask

	function automatic logic [95:0] rand_rx();
		return {$random(seed), $random(seed), $random(seed)};
	endfunction

	task automatic mem_put(logic [14:0] key, logic [47:0] data);
		exp_mem[key] = data;
		exp_vld[key] = 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// Model of start, tracker and write rules
	////////////////////////////////////////////////////////////
	task automatic model_slot();
		logic [13:0] sum;
		sum = '0;
		for (int k = 0; k < NU; k++)
		begin
			m_start[k] = sum;
			m_addr[k]  = sum;
			m_cnt[k]   = '0;
			m_page[k]  = 1'b0;
			m_cb[k]    = 0;
			sum = sum + 14'(16 * (i_user_cfg[k].e1_sz / 16 + 1));
		end
	endtask

	task automatic model_beat(int u, logic [95:0] rx);
		drm_pkg::user_cfg_t c;
		int                 w;
		logic [95:0]        mask;
		logic [15:0]        limit;
		logic [13:0]        step;
		c = i_user_cfg[u];
		if (!c.two_layer)
			mem_put({m_page[u], m_addr[u]}, rx[47:0]);
		else
		begin
			case (c.qm)
				4'd1, 4'd2, 4'd4, 4'd6, 4'd8: w = 6 * c.qm;
				default: w = 0;   // Unsupported Qm gives zero words
			endcase
			mask = (96'd1 << w) - 96'd1;
			mem_put({m_page[u], m_addr[u][13:1], 1'b0}, 48'(rx & mask));
			mem_put({m_page[u], m_addr[u][13:1], 1'b1}, 48'((rx >> w) & mask));
		end
		limit = (m_cb[u] < c.e0_num) ? c.e0_sz : c.e1_sz;
		step  = c.two_layer ? 14'd2 : 14'd1;
		if (m_cnt[u] < limit)
		begin
			m_cnt[u]  = m_cnt[u] + step;
			m_addr[u] = m_addr[u] + step;
		end
		else
		begin
			m_cnt[u]  = '0;
			m_addr[u] = m_start[u];
			m_page[u] = ~m_page[u];
			m_cb[u]   = m_cb[u] + 1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Drivers and checkers
	////////////////////////////////////////////////////////////
	task automatic start_slot();
		i_slot_start = 1'b1;
		tick();
		i_slot_start = 1'b0;
		model_slot();
		repeat (12) tick();
	endtask

	task automatic send_beat(int u, logic [95:0] rx);
		i_beat_strb     = 1'b1;
		i_beat.user_idx = 4'(u);
		i_beat.rx       = rx;
		if (u < NU)
			model_beat(u, rx);
		tick();   // Buffer writes on this edge
		i_beat_strb = 1'b0;
	endtask

	task automatic read_word(logic [14:0] addr, output logic [47:0] data);
		int n;
		i_rd_req  = 1'b1;
		i_rd_addr = addr;
		n = 0;
		while (!o_rd_ack && n < TMO)
		begin
			tick();
			n++;
		end
		assert (o_rd_ack)
		else
		begin
			errors++;
			$display("Read of address %h timed out waiting for the acknowledge", addr);
		end
		data     = o_rd_data;
		i_rd_req = 1'b0;
		n = 0;
		while (o_rd_ack && n < TMO)
		begin
			tick();
			n++;
		end
		assert (!o_rd_ack)
		else
		begin
			errors++;
			$display("Acknowledge stayed high after the read of address %h", addr);
		end
	endtask

	task automatic check_word(logic [14:0] addr, logic [47:0] exp);
		logic [47:0] got;
		read_word(addr, got);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("ERROR: o_rd_data at address %h is %h, expected %h", addr, got, exp);
		end
	endtask

	task automatic check_all();
		for (int k = 0; k < 32768; k++)
		begin
			if (exp_vld[k])
				check_word(15'(k), exp_mem[k]);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////
	task automatic test_start_one_layer();
		for (int k = 0; k < NU; k++)
		begin
			i_user_cfg[k].e0_sz     = 16'd100;
			i_user_cfg[k].e1_sz     = 16'(40 + 7 * k);
			i_user_cfg[k].e0_num    = 8'd0;
			i_user_cfg[k].qm        = 4'd2;
			i_user_cfg[k].two_layer = 1'b0;
		end
		start_slot();
		for (int n = 0; n < 6; n++)
		begin
			send_beat(0, rand_rx());
			rx_hist[n] = rand_rx();
			send_beat(3, rx_hist[n]);
			send_beat(7, rand_rx());
		end
		check_word(15'd160, rx_hist[0][47:0]);   // 48 + 48 + 64 before user 3
		check_all();
	endtask

	task automatic test_cb_wrap();
		i_user_cfg[2].e0_sz  = 16'd5;
		i_user_cfg[2].e1_sz  = 16'd9;
		i_user_cfg[2].e0_num = 8'd2;
		start_slot();
		// Two E0 blocks of 6 beats and one E1 block of 10
		for (int n = 0; n < 22; n++)
		begin
			rx_hist[n] = rand_rx();
			send_beat(2, rx_hist[n]);
		end
		check_word({1'b1, 14'd96}, rx_hist[6][47:0]);
		check_word({1'b0, 14'd96}, rx_hist[12][47:0]);
		check_word({1'b0, 14'd102}, rx_hist[18][47:0]);   // Beyond the E0 length
		check_word({1'b0, 14'd105}, rx_hist[21][47:0]);
		check_all();
	endtask

	task automatic test_two_layer();
		i_user_cfg[1].qm        = 4'd2;
		i_user_cfg[4].qm        = 4'd6;
		i_user_cfg[6].qm        = 4'd8;
		i_user_cfg[1].two_layer = 1'b1;
		i_user_cfg[4].two_layer = 1'b1;
		i_user_cfg[6].two_layer = 1'b1;
		start_slot();
		for (int n = 0; n < 4; n++)
		begin
			send_beat(1, rand_rx());
			send_beat(4, rand_rx());
			send_beat(6, rand_rx());
		end
		check_all();
	endtask

	task automatic test_interleave();
		int u;
		start_slot();
		for (int n = 0; n < 30; n++)
		begin
			u = $unsigned($random(seed)) % NU;
			send_beat(u, rand_rx());
		end
		send_beat(9, rand_rx());   // Out of range so nothing is written
		// One more beat per user shows that no tracker moved
		for (int k = 0; k < NU; k++)
			send_beat(k, rand_rx());
		check_all();
	endtask

	task automatic test_new_slot();
		logic [95:0] rx;
		int          n;
		// Leave user 2 on page 1 part way into a block
		n = 0;
		while (!(m_page[2] && m_cnt[2] != 14'd0) && n < 32)
		begin
			send_beat(2, rand_rx());
			n++;
		end
		start_slot();
		rx = rand_rx();
		send_beat(2, rx);
		check_word({1'b0, 14'd96}, rx[47:0]);   // 48 + 48 before user 2
		for (int k = 0; k < 5; k++)
			send_beat(2, rand_rx());
		// Seventh beat of the slot opens the second E0 block on page 1
		rx = rand_rx();
		send_beat(2, rx);
		check_word({1'b1, 14'd96}, rx[47:0]);
		check_all();
	endtask

	initial
	begin
		i_core_clk   = 1'b0;
		i_rx_rstn    = 1'b0;
		i_slot_start = 1'b0;
		i_user_cfg   = '0;
		i_beat_strb  = 1'b0;
		i_beat       = '0;
		i_rd_req     = 1'b0;
		i_rd_addr    = '0;
		repeat (4) @(posedge i_core_clk);
		#2;
		i_rx_rstn = 1'b1;
		tick();
		assert (o_rd_ack === 1'b0)
		else
		begin
			errors++;
			$display("ERROR: o_rd_ack after reset is %h, expected 0", o_rd_ack);
		end
		test_start_one_layer();
		test_cb_wrap();
		test_two_layer();
		test_interleave();
		test_new_slot();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- list.f
rtl/drm_pkg.sv
rtl/drm_start_calc.sv
rtl/drm_user_tracker.sv
rtl/drm_wr_format.sv
rtl/drm_llr_buffer.sv
rtl/drm_top.sv
verif/tb_drm_top.sv

//--- Bender.yml
package:
  name: drm_input_buffer

sources:
  - files:
      - rtl/drm_pkg.sv
      - rtl/drm_start_calc.sv
      - rtl/drm_user_tracker.sv
      - rtl/drm_wr_format.sv
      - rtl/drm_llr_buffer.sv
      - rtl/drm_top.sv
  - target: simulation
    files:
      - verif/tb_drm_top.sv
